//--- bench/tb_fpga_core.sv
// FPGA core testbench
`timescale 1ns/10ps
`include "eth_loop_config.svh"

module tb_fpga_core
    import eth_loop_pkg::*;
();

    localparam int FRAME_COUNT      = 9;
    localparam int FRAME_BYTES      = 3 * 20 + 2 * `SLOT_BYTES + 1 + 10 + 33 + 5 + 48;
    localparam int FRAME_WAIT       = 4 * `SLOT_BYTES + 8 * `IFG_BYTES + 100;
    localparam int UART_BYTE_CYCLES = 11 * `UART_BIT_CYCLES;
    localparam int WATCHDOG_CYCLES  = 2 * (FRAME_BYTES + FRAME_COUNT * `IFG_BYTES)
                                      + 2 * FRAME_COUNT * FRAME_WAIT
                                      + 12 * UART_BYTE_CYCLES + 200;

    logic       clk;
    logic       rst_n;
    logic [7:0] sw;
    logic [7:0] led;
    logic       uart_rxd;
    logic       uart_txd;
    logic       uart_rts;
    logic       gmii_clk_en;
    byte_t      gmii_rxd;
    logic       gmii_rx_dv;
    logic       gmii_rx_er;
    byte_t      gmii_txd;
    logic       gmii_tx_en;
    logic       gmii_tx_er;

    integer     seed = 32'hed9a_4a90;
    int         errors = 0;
    int         checks = 0;

    // Monitor captures and expected frames, flattened
    byte_t      gmii_bytes[$];
    int         gmii_lens[$];
    byte_t      exp_bytes[$];
    int         exp_lens[$];
    byte_t      uart_bytes[$];

    bit         in_frame = 1'b0;
    bit         seen_frame = 1'b0;
    int         cur_len = 0;
    int         idle_cnt = 0;

    fpga_core DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .sw          (sw),
        .led         (led),
        .uart_rxd    (uart_rxd),
        .uart_txd    (uart_txd),
        .uart_rts    (uart_rts),
        .gmii_clk_en (gmii_clk_en),
        .gmii_rxd    (gmii_rxd),
        .gmii_rx_dv  (gmii_rx_dv),
        .gmii_rx_er  (gmii_rx_er),
        .gmii_txd    (gmii_txd),
        .gmii_tx_en  (gmii_tx_en),
        .gmii_tx_er  (gmii_tx_er)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // 10/100 style enable, high every other cycle
    initial begin
        gmii_clk_en = 1'b0;
        forever begin
            @(posedge clk);
            #1 gmii_clk_en = ~gmii_clk_en;
        end
    end

    task check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task report_and_finish();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    // Negedge after an enabled edge, outputs are settled
    always @(negedge clk) begin
        if (!gmii_clk_en) begin
            // No transmit errors are ever signalled
            check_eq("gmii_tx_er", 32'(gmii_tx_er), 32'd0);
            if (gmii_tx_en === 1'b1) begin
                if (!in_frame && seen_frame && idle_cnt < `IFG_BYTES) begin
                    $display("Interframe gap of %0d enabled cycles is too short", idle_cnt);
                    errors++;
                end
                in_frame = 1'b1;
                gmii_bytes.push_back(gmii_txd);
                cur_len++;
            end else if (in_frame) begin
                gmii_lens.push_back(cur_len);
                cur_len    = 0;
                in_frame   = 1'b0;
                seen_frame = 1'b1;
                idle_cnt   = 1;
            end else begin
                idle_cnt++;
            end
        end
    end

    // UART decoder for the echo line
    always begin : uart_decode
        byte_t b;
        int    i;
        @(negedge clk);
        if (uart_txd === 1'b0) begin
            repeat (`UART_BIT_CYCLES / 2) @(negedge clk);
            if (uart_txd !== 1'b0) begin
                $display("Start bit on uart_txd did not last to its middle");
                errors++;
            end
            for (i = 0; i < 8; i++) begin
                repeat (`UART_BIT_CYCLES) @(negedge clk);
                b[i] = uart_txd;
            end
            repeat (`UART_BIT_CYCLES) @(negedge clk);
            if (uart_txd !== 1'b1) begin
                $display("Stop bit on uart_txd was low");
                errors++;
            end
            uart_bytes.push_back(b);
        end
    end

    // Waits for the next cycle that will be enabled, then drives one byte
    task drive_gmii(input byte_t d, input logic dv, input logic er);
        @(posedge clk);
        while (gmii_clk_en) @(posedge clk);
        #1;
        gmii_rxd   = d;
        gmii_rx_dv = dv;
        gmii_rx_er = er;
    endtask

    task send_frame(input int len, input int err_at, input bit expect_back);
        byte_t b;
        int    i;
        for (i = 0; i < len; i++) begin
            b = byte_t'($random(seed));
            drive_gmii(b, 1'b1, i == err_at);
            if (expect_back) begin
                exp_bytes.push_back(b);
            end
        end
        if (expect_back) begin
            exp_lens.push_back(len);
        end
        repeat (`IFG_BYTES) drive_gmii(8'h00, 1'b0, 1'b0);
    endtask

    task clear_queues();
        gmii_bytes.delete();
        gmii_lens.delete();
        exp_bytes.delete();
        exp_lens.delete();
    endtask

    task wait_frames(input int n);
        int i;
        i = 0;
        while (gmii_lens.size() < n && i < n * FRAME_WAIT) begin
            @(posedge clk);
            i++;
        end
        if (gmii_lens.size() < n) begin
            $display("Timed out waiting for %0d frames, saw %0d", n, gmii_lens.size());
            errors++;
        end
    endtask

    task compare_frames();
        int i;
        check_eq("frame count", 32'(gmii_lens.size()), 32'(exp_lens.size()));
        if (gmii_lens.size() == exp_lens.size()) begin
            for (i = 0; i < exp_lens.size(); i++) begin
                check_eq("frame length", 32'(gmii_lens[i]), 32'(exp_lens[i]));
            end
        end
        if (gmii_bytes.size() == exp_bytes.size()) begin
            for (i = 0; i < exp_bytes.size(); i++) begin
                check_eq("gmii_txd", 32'(gmii_bytes[i]), 32'(exp_bytes[i]));
            end
        end
    endtask

    task uart_bit(input logic b);
        @(posedge clk);
        #1 uart_rxd = b;
        repeat (`UART_BIT_CYCLES - 1) @(posedge clk);
    endtask

    // One idle bit after the stop bit keeps the echo from falling behind
    task send_uart_byte(input byte_t d, input logic stop);
        int i;
        uart_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            uart_bit(d[i]);
        end
        uart_bit(stop);
        uart_bit(1'b1);
    endtask

    task wait_uart(input int n);
        int i;
        i = 0;
        while (uart_bytes.size() < n && i < 2 * n * UART_BYTE_CYCLES) begin
            @(posedge clk);
            i++;
        end
        if (uart_bytes.size() < n) begin
            $display("Timed out waiting for %0d echoed bytes, saw %0d", n, uart_bytes.size());
            errors++;
        end
    endtask

    task test_leds();
        logic [7:0] vals [4];
        int         i;
        vals[0] = 8'h00;
        vals[1] = 8'hff;
        vals[2] = 8'ha5;
        vals[3] = 8'h3c;
        for (i = 0; i < 4; i++) begin
            @(posedge clk);
            #1 sw = vals[i];
            @(negedge clk);
            check_eq("led", 32'(led), 32'(vals[i]));
        end
    endtask

    task test_single_frame();
        clear_queues();
        send_frame(20, -1, 1'b1);
        wait_frames(1);
        compare_frames();
    endtask

    // Errored frame first, so a leak would show up ahead of the good one
    task test_error_frame();
        clear_queues();
        send_frame(20, 7, 1'b0);
        send_frame(20, -1, 1'b1);
        wait_frames(1);
        repeat (FRAME_WAIT) @(posedge clk);
        compare_frames();
    endtask

    task test_frame_size();
        clear_queues();
        send_frame(`SLOT_BYTES + 1, -1, 1'b0);
        send_frame(`SLOT_BYTES, -1, 1'b1);
        wait_frames(1);
        repeat (FRAME_WAIT) @(posedge clk);
        compare_frames();
    endtask

    task test_back_to_back();
        clear_queues();
        send_frame(10, -1, 1'b1);
        send_frame(33, -1, 1'b1);
        send_frame(5, -1, 1'b1);
        send_frame(48, -1, 1'b1);
        wait_frames(4);
        compare_frames();
    endtask

    task test_uart_echo();
        byte_t sent [3];
        int    i;
        sent[0] = 8'h41;
        sent[1] = 8'ha7;
        sent[2] = 8'h3c;
        uart_bytes.delete();
        for (i = 0; i < 3; i++) begin
            send_uart_byte(sent[i], 1'b1);
        end
        wait_uart(3);
        check_eq("uart echo count", 32'(uart_bytes.size()), 32'd3);
        for (i = 0; i < 3 && i < uart_bytes.size(); i++) begin
            check_eq("uart_txd byte", 32'(uart_bytes[i]), 32'(sent[i]));
        end
        // No flow control, so RTS stays low through traffic
        check_eq("uart_rts", 32'(uart_rts), 32'd0);
        // Let the last echo finish, then send a framing error
        repeat (2 * `UART_BIT_CYCLES) @(posedge clk);
        send_uart_byte(8'h96, 1'b0);
        repeat (12 * `UART_BIT_CYCLES) @(posedge clk);
        check_eq("uart echo count", 32'(uart_bytes.size()), 32'd3);
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        errors++;
        report_and_finish();
    end

    initial begin
        rst_n      = 1'b0;
        sw         = 8'h00;
        uart_rxd   = 1'b1;
        gmii_rxd   = 8'h00;
        gmii_rx_dv = 1'b0;
        gmii_rx_er = 1'b0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (5) @(posedge clk);

        test_leds();
        test_single_frame();
        test_error_frame();
        test_frame_size();
        test_back_to_back();
        test_uart_echo();

        report_and_finish();
    end

endmodule

//--- design/eth_loop_config.svh
// Ethernet loopback build constants
`ifndef ETH_LOOP_CONFIG_SVH
`define ETH_LOOP_CONFIG_SVH

// Frame buffer geometry
`define FRAME_SLOTS 4
`define SLOT_BYTES 64

// Minimum idle enabled cycles between transmitted frames
`define IFG_BYTES 12

// Clock cycles per UART bit, short enough for simulation
`define UART_BIT_CYCLES 16

`endif

//--- design/eth_loop_pkg.sv
// Ethernet loopback types
`include "eth_loop_config.svh"

package eth_loop_pkg;

    typedef logic [7:0] byte_t;

    // Slot index in the upper bits, byte offset in the lower bits
    typedef logic [$clog2(`FRAME_SLOTS*`SLOT_BYTES)-1:0] mem_addr_t;
    typedef logic [$clog2(`FRAME_SLOTS)-1:0] slot_t;

    // Holds 1 to SLOT_BYTES
    typedef logic [$clog2(`SLOT_BYTES+1)-1:0] frame_len_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_STORE,
        RX_DISCARD
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_FETCH,
        TX_SEND,
        TX_GAP
    } tx_state_t;

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_t;

endpackage

//--- design/fpga_core.sv
// FPGA core logic
`timescale 1ns/10ps

module fpga_core
    import eth_loop_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // GPIO
    input  logic [7:0] sw,
    output logic [7:0] led,

    // UART, 8N1
    input  logic       uart_rxd,
    output logic       uart_txd,
    output logic       uart_rts,

    // Ethernet, GMII with clock enable
    input  logic       gmii_clk_en,
    input  byte_t      gmii_rxd,
    input  logic       gmii_rx_dv,
    input  logic       gmii_rx_er,
    output byte_t      gmii_txd,
    output logic       gmii_tx_en,
    output logic       gmii_tx_er
);

    logic       frame_commit;
    slot_t      commit_slot;
    frame_len_t commit_len;
    logic       slot_release;

    assign led        = sw;
    assign uart_rts   = 1'b0;
    assign gmii_tx_er = 1'b0;

    uart_echo uart_echo_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .uart_rxd (uart_rxd),
        .uart_txd (uart_txd)
    );

    // Shared frame buffer ports
    frame_mem_if rx_port ();
    frame_mem_if tx_port ();

    frame_mem_arbiter frame_mem_arbiter_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx_port (rx_port),
        .tx_port (tx_port)
    );

    gmii_frame_rx gmii_frame_rx_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .gmii_clk_en  (gmii_clk_en),
        .gmii_rxd     (gmii_rxd),
        .gmii_rx_dv   (gmii_rx_dv),
        .gmii_rx_er   (gmii_rx_er),
        .mem          (rx_port),
        .frame_commit (frame_commit),
        .commit_slot  (commit_slot),
        .commit_len   (commit_len),
        .slot_release (slot_release)
    );

    gmii_frame_tx gmii_frame_tx_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .gmii_clk_en  (gmii_clk_en),
        .mem          (tx_port),
        .frame_commit (frame_commit),
        .commit_slot  (commit_slot),
        .commit_len   (commit_len),
        .slot_release (slot_release),
        .gmii_txd     (gmii_txd),
        .gmii_tx_en   (gmii_tx_en)
    );

endmodule

//--- design/frame_mem_arbiter.sv
// Frame buffer arbiter
`timescale 1ns/10ps
`include "eth_loop_config.svh"

module frame_mem_arbiter
    import eth_loop_pkg::*;
(
    input logic          clk,
    input logic          rst_n,
    frame_mem_if.arbiter rx_port,
    frame_mem_if.arbiter tx_port
);

    byte_t     mem [`FRAME_SLOTS*`SLOT_BYTES];

    logic      last_tx;
    logic      gnt_rx;
    logic      gnt_tx;
    logic      wr_en;
    logic      rd_en;
    mem_addr_t acc_addr;
    byte_t     acc_wdata;
    byte_t     rd_data;

    // Round robin, rx wins unless it was served last under contention
    always_comb begin
        gnt_rx    = rx_port.req && (!tx_port.req || last_tx);
        gnt_tx    = tx_port.req && !gnt_rx;
        acc_addr  = gnt_tx ? tx_port.addr : rx_port.addr;
        acc_wdata = gnt_tx ? tx_port.wdata : rx_port.wdata;
        wr_en     = (gnt_rx && rx_port.we) || (gnt_tx && tx_port.we);
        rd_en     = (gnt_rx || gnt_tx) && !wr_en;
    end

    assign rx_port.gnt   = gnt_rx;
    assign tx_port.gnt   = gnt_tx;
    assign rx_port.rdata = rd_data;
    assign tx_port.rdata = rd_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_tx <= 1'b0;
        end else if (gnt_rx) begin
            last_tx <= 1'b0;
        end else if (gnt_tx) begin
            last_tx <= 1'b1;
        end
    end

    // Single ported byte array
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[acc_addr] <= acc_wdata;
        end
        if (rd_en) begin
            rd_data <= mem[acc_addr];
        end
    end

    a_one_grant: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(rx_port.gnt && tx_port.gnt)
    );

    a_grant_requested: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rx_port.gnt -> rx_port.req) && (tx_port.gnt -> tx_port.req)
    );

endmodule

//--- design/frame_mem_if.sv
// Frame buffer access port
`timescale 1ns/10ps

interface frame_mem_if
    import eth_loop_pkg::*;
();

    // Held by the peer until granted
    logic      req;
    logic      we;
    mem_addr_t addr;
    byte_t     wdata;

    // Returned by the arbiter
    logic      gnt;
    byte_t     rdata;   // one cycle after a read grant

    modport peer (
        output req,
        output we,
        output addr,
        output wdata,
        input  gnt,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output gnt,
        output rdata
    );

endinterface

//--- design/gmii_frame_rx.sv
// GMII frame receiver
`timescale 1ns/10ps
`include "eth_loop_config.svh"

module gmii_frame_rx
    import eth_loop_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       gmii_clk_en,
    input  byte_t      gmii_rxd,
    input  logic       gmii_rx_dv,
    input  logic       gmii_rx_er,
    frame_mem_if.peer  mem,
    output logic       frame_commit,
    output slot_t      commit_slot,
    output frame_len_t commit_len,
    input  logic       slot_release
);

    localparam int OFS_W  = $clog2(`SLOT_BYTES);
    localparam int USED_W = $clog2(`FRAME_SLOTS + 1);

    rx_state_t         state;
    slot_t             wr_slot;
    logic [USED_W-1:0] used;
    frame_len_t        count;
    logic [OFS_W-1:0]  wr_ofs;
    logic              slots_full;
    logic              take_byte;
    logic              closing;
    logic              commit_now;
    logic              pend_valid;
    mem_addr_t         pend_addr;
    byte_t             pend_data;

    assign slots_full = (used == USED_W'(`FRAME_SLOTS));
    assign wr_ofs     = (state == RX_IDLE) ? '0 : count[OFS_W-1:0];

    // Commit once the last byte has reached the buffer
    assign commit_now = closing && (!pend_valid || mem.gnt);

    // One byte write buffer toward the arbiter
    assign mem.req   = pend_valid;
    assign mem.we    = 1'b1;
    assign mem.addr  = pend_addr;
    assign mem.wdata = pend_data;

    always_comb begin
        take_byte = 1'b0;
        if (gmii_clk_en && gmii_rx_dv && !gmii_rx_er) begin
            if (state == RX_IDLE) begin
                take_byte = !slots_full;
            end else if (state == RX_STORE) begin
                take_byte = (count != frame_len_t'(`SLOT_BYTES));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= RX_IDLE;
            wr_slot      <= '0;
            used         <= '0;
            count        <= '0;
            closing      <= 1'b0;
            pend_valid   <= 1'b0;
            frame_commit <= 1'b0;
        end else begin
            frame_commit <= commit_now;
            used <= used + USED_W'(commit_now) - USED_W'(slot_release);

            if (take_byte) begin
                pend_valid <= 1'b1;
            end else if (mem.gnt) begin
                pend_valid <= 1'b0;
            end

            if (commit_now) begin
                closing <= 1'b0;
                wr_slot <= wr_slot + 1'b1;
            end

            if (gmii_clk_en) begin
                case (state)
                    RX_IDLE: begin
                        if (gmii_rx_dv) begin
                            state <= take_byte ? RX_STORE : RX_DISCARD;
                            count <= frame_len_t'(1);
                        end
                    end
                    RX_STORE: begin
                        if (!gmii_rx_dv) begin
                            state   <= RX_IDLE;
                            closing <= 1'b1;
                        end else if (take_byte) begin
                            count <= count + 1'b1;
                        end else begin
                            // Error or oversize
                            state <= RX_DISCARD;
                        end
                    end
                    RX_DISCARD: begin
                        if (!gmii_rx_dv) begin
                            state <= RX_IDLE;
                        end
                    end
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_byte) begin
            pend_data <= gmii_rxd;
            pend_addr <= {wr_slot, wr_ofs};
        end
        if (commit_now) begin
            commit_slot <= wr_slot;
            commit_len  <= count;
        end
    end

    // Slot availability was checked at frame start
    a_commit_has_slot: assert property (
        @(posedge clk) disable iff (!rst_n)
        commit_now |-> !slots_full
    );

endmodule

//--- design/gmii_frame_tx.sv
// GMII frame transmitter
`timescale 1ns/10ps
`include "eth_loop_config.svh"

module gmii_frame_tx
    import eth_loop_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       gmii_clk_en,
    frame_mem_if.peer  mem,
    input  logic       frame_commit,
    input  slot_t      commit_slot,
    input  frame_len_t commit_len,
    output logic       slot_release,
    output byte_t      gmii_txd,
    output logic       gmii_tx_en
);

    localparam int OFS_W = $clog2(`SLOT_BYTES);
    localparam int QP_W  = $clog2(`FRAME_SLOTS);
    localparam int GAP_W = $clog2(`IFG_BYTES);

    tx_state_t        state;
    slot_t            q_slot [`FRAME_SLOTS];
    frame_len_t       q_len [`FRAME_SLOTS];
    logic [QP_W-1:0]  q_wp;
    logic [QP_W-1:0]  q_rp;
    logic [QP_W:0]    q_cnt;
    logic             q_pop;
    slot_t            cur_slot;
    frame_len_t       cur_len;
    frame_len_t       rd_ofs;
    frame_len_t       tx_cnt;
    logic             rd_inflight;
    byte_t            fbuf [2];
    logic             f_wp;
    logic             f_rp;
    logic [1:0]       f_cnt;
    logic             f_pop;
    logic [GAP_W-1:0] gap_cnt;

    assign q_pop = (state == TX_IDLE) && (q_cnt != '0);
    assign f_pop = (state == TX_SEND) && gmii_clk_en;

    // Keep up to two bytes fetched or in flight ahead of the line
    assign mem.req   = (state == TX_FETCH || state == TX_SEND) && (rd_ofs != cur_len)
                       && (f_cnt + 2'(rd_inflight) < 2'd2);
    assign mem.we    = 1'b0;
    assign mem.wdata = '0;
    assign mem.addr  = {cur_slot, rd_ofs[OFS_W-1:0]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= TX_IDLE;
            q_wp         <= '0;
            q_rp         <= '0;
            q_cnt        <= '0;
            rd_ofs       <= '0;
            tx_cnt       <= '0;
            rd_inflight  <= 1'b0;
            f_wp         <= 1'b0;
            f_rp         <= 1'b0;
            f_cnt        <= '0;
            gap_cnt      <= '0;
            gmii_tx_en   <= 1'b0;
            slot_release <= 1'b0;
        end else begin
            slot_release <= 1'b0;
            rd_inflight  <= mem.req && mem.gnt;

            if (frame_commit) begin
                q_wp <= q_wp + 1'b1;
            end
            if (q_pop) begin
                q_rp <= q_rp + 1'b1;
            end
            q_cnt <= q_cnt + (QP_W+1)'(frame_commit) - (QP_W+1)'(q_pop);

            if (rd_inflight) begin
                f_wp <= ~f_wp;
            end
            if (f_pop) begin
                f_rp <= ~f_rp;
            end
            f_cnt <= f_cnt + 2'(rd_inflight) - 2'(f_pop);

            if (mem.req && mem.gnt) begin
                rd_ofs <= rd_ofs + 1'b1;
            end

            case (state)
                TX_IDLE: begin
                    if (q_pop) begin
                        state  <= TX_FETCH;
                        rd_ofs <= '0;
                        tx_cnt <= '0;
                    end
                end
                TX_FETCH: begin
                    if (f_cnt == 2'd2 || (rd_ofs == cur_len && f_cnt != '0)) begin
                        state <= TX_SEND;
                    end
                end
                TX_SEND: begin
                    if (gmii_clk_en) begin
                        gmii_tx_en <= 1'b1;
                        tx_cnt     <= tx_cnt + 1'b1;
                        if (tx_cnt + 1'b1 == cur_len) begin
                            state        <= TX_GAP;
                            gap_cnt      <= '0;
                            slot_release <= 1'b1;
                        end
                    end
                end
                TX_GAP: begin
                    if (gmii_clk_en) begin
                        gmii_tx_en <= 1'b0;
                        gap_cnt    <= gap_cnt + 1'b1;
                        if (gap_cnt == GAP_W'(`IFG_BYTES - 1)) begin
                            state <= TX_IDLE;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (frame_commit) begin
            q_slot[q_wp] <= commit_slot;
            q_len[q_wp]  <= commit_len;
        end
        if (q_pop) begin
            cur_slot <= q_slot[q_rp];
            cur_len  <= q_len[q_rp];
        end
        if (rd_inflight) begin
            fbuf[f_wp] <= mem.rdata;
        end
        if (f_pop) begin
            gmii_txd <= fbuf[f_rp];
        end
    end

    // Receiver holds every queued slot, so it cannot overrun the queue
    a_queue_room: assert property (
        @(posedge clk) disable iff (!rst_n)
        frame_commit |-> q_cnt != (QP_W+1)'(`FRAME_SLOTS)
    );

    // Arbiter latency must keep a byte ready at each enabled cycle
    a_no_underrun: assert property (
        @(posedge clk) disable iff (!rst_n)
        f_pop |-> f_cnt != '0
    );

endmodule

//--- design/uart_echo.sv
// UART echo
`timescale 1ns/10ps
`include "eth_loop_config.svh"

module uart_echo
    import eth_loop_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic uart_rxd,
    output logic uart_txd
);

    localparam int CNT_W = $clog2(`UART_BIT_CYCLES);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`UART_BIT_CYCLES - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`UART_BIT_CYCLES / 2 - 1);

    logic [1:0]       rxd_sync;
    uart_state_t      rx_state;
    uart_state_t      tx_state;
    logic [CNT_W-1:0] rx_cnt;
    logic [CNT_W-1:0] tx_cnt;
    logic [2:0]       rx_bit;
    logic [2:0]       tx_bit;
    byte_t            rx_shift;
    byte_t            tx_shift;
    byte_t            hold_data;
    logic             rx_done;
    logic             hold_valid;
    logic             tx_take;

    assign tx_take = (tx_state == UART_IDLE) && hold_valid;

    // Receiver, samples mid bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_sync <= 2'b11;
            rx_state <= UART_IDLE;
            rx_cnt   <= '0;
            rx_bit   <= '0;
            rx_done  <= 1'b0;
        end else begin
            rxd_sync <= {rxd_sync[0], uart_rxd};
            rx_done  <= 1'b0;
            case (rx_state)
                UART_IDLE: begin
                    rx_cnt <= '0;
                    if (!rxd_sync[1]) begin
                        rx_state <= UART_START;
                    end
                end
                UART_START: begin
                    if (rx_cnt == HALF_LAST) begin
                        rx_cnt   <= '0;
                        rx_bit   <= '0;
                        // Glitch check on the start bit
                        rx_state <= rxd_sync[1] ? UART_IDLE : UART_DATA;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                UART_DATA: begin
                    if (rx_cnt == BIT_LAST) begin
                        rx_cnt   <= '0;
                        rx_shift <= {rxd_sync[1], rx_shift[7:1]};
                        rx_bit   <= rx_bit + 1'b1;
                        if (rx_bit == 3'd7) begin
                            rx_state <= UART_STOP;
                        end
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                UART_STOP: begin
                    if (rx_cnt == BIT_LAST) begin
                        // Framing error drops the byte
                        rx_done  <= rxd_sync[1];
                        rx_state <= UART_IDLE;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                default: rx_state <= UART_IDLE;
            endcase
        end
    end

    // Holding register, newest byte wins
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
        end else if (rx_done) begin
            hold_valid <= 1'b1;
        end else if (tx_take) begin
            hold_valid <= 1'b0;
        end
        if (rx_done) begin
            hold_data <= rx_shift;
        end
    end

    // Transmitter, 8N1 LSB first
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_state <= UART_IDLE;
            tx_cnt   <= '0;
            tx_bit   <= '0;
            uart_txd <= 1'b1;
        end else begin
            case (tx_state)
                UART_IDLE: begin
                    tx_cnt <= '0;
                    if (tx_take) begin
                        tx_shift <= hold_data;
                        uart_txd <= 1'b0;
                        tx_state <= UART_START;
                    end
                end
                UART_START: begin
                    if (tx_cnt == BIT_LAST) begin
                        tx_cnt   <= '0;
                        tx_bit   <= '0;
                        uart_txd <= tx_shift[0];
                        tx_state <= UART_DATA;
                    end else begin
                        tx_cnt <= tx_cnt + 1'b1;
                    end
                end
                UART_DATA: begin
                    if (tx_cnt == BIT_LAST) begin
                        tx_cnt   <= '0;
                        tx_shift <= tx_shift >> 1;
                        tx_bit   <= tx_bit + 1'b1;
                        if (tx_bit == 3'd7) begin
                            uart_txd <= 1'b1;
                            tx_state <= UART_STOP;
                        end else begin
                            uart_txd <= tx_shift[1];
                        end
                    end else begin
                        tx_cnt <= tx_cnt + 1'b1;
                    end
                end
                UART_STOP: begin
                    if (tx_cnt == BIT_LAST) begin
                        tx_state <= UART_IDLE;
                    end else begin
                        tx_cnt <= tx_cnt + 1'b1;
                    end
                end
                default: tx_state <= UART_IDLE;
            endcase
        end
    end

endmodule

//--- fpga_core.f
+incdir+design
design/eth_loop_pkg.sv
design/frame_mem_if.sv
design/frame_mem_arbiter.sv
design/gmii_frame_rx.sv
design/gmii_frame_tx.sv
design/uart_echo.sv
design/fpga_core.sv
bench/tb_fpga_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fpga_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_fpga_core \
    -f fpga_core.f \
    -o sim_fpga_core

output=$(./obj_dir/sim_fpga_core)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qF -- '>>> PASS'; then
    exit 0
else
    exit 1
fi
